// ==== flist.f ====
hw/deparser_pkg.sv
hw/sync_fifo.sv
hw/sub_deparser.sv
hw/deparse_act_ram.sv
hw/deparser.sv
hw/deparser_top.sv
dv/deparser_checker.sv
dv/deparser_tb.sv

// ==== Bender.yml ====
package:
  name: deparser

sources:
  # rtl
  - files:
      - hw/deparser_pkg.sv
      - hw/sync_fifo.sv
      - hw/sub_deparser.sv
      - hw/deparse_act_ram.sv
      - hw/deparser.sv
      - hw/deparser_top.sv
  # testbench
  - target: test
    files:
      - dv/deparser_checker.sv
      - dv/deparser_tb.sv

// ==== dv/deparser_tb.sv ====
`default_nettype none

module deparser_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import deparser_pkg::*;

	localparam int timeout_cycles = 400;

	logic clk = 1'b0;
	logic aresetn;
	logic [data_w-1:0] s_pkt_data;
	logic [keep_w-1:0] s_pkt_keep;
	logic [user_w-1:0] s_pkt_user;
	logic s_pkt_last;
	logic s_pkt_valid;
	logic s_pkt_ready;
	phv_t s_phv;
	logic s_phv_valid;
	logic s_phv_ready;
	logic [data_w-1:0] m_data;
	logic [keep_w-1:0] m_keep;
	logic [user_w-1:0] m_user;
	logic m_last;
	logic m_valid;
	logic m_ready;
	logic psel;
	logic penable;
	logic pwrite;
	logic [apb_addr_w-1:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;

	logic [31:0] lfsr = 32'hc76c_7ff7;
	logic [31:0] rdy_lfsr = 32'hc76c_7ff7; // own stream for m_ready
	logic bp_en = 1'b0;
	int errors = 0;
	int timeouts = 0;
	logic [63:0] prof_bits [prof_depth]; // profile RAM model
	pkt_beat_t in_q [$];
	pkt_beat_t exp_q [$];
	phv_t phv_q [$];

	deparser_top i_deparser_top (.*);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		#2;
		if (bp_en) begin
			rdy_lfsr = lfsr_next(rdy_lfsr);
			m_ready = rdy_lfsr[0];
		end else begin
			m_ready = 1'b1;
		end
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one step per bit
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			r[i] = lfsr[0];
		end
		return r;
	endfunction

	function automatic int size_bytes(input cont_size_t s);
		case (s)
			size_2b: return 2;
			size_4b: return 4;
			size_6b: return 6;
			default: return 0;
		endcase
	endfunction

	function automatic deparse_act_t mk_act(input logic v, input cont_size_t s,
		input int idx, input int off);
		return '{rsvd: '0, offset: 4'(off), idx: 2'(idx), size: s, valid: v};
	endfunction

	task automatic check_beat(input pkt_beat_t got, input pkt_beat_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("Error at %0t ns: %s got %h/%h/%h/%b expected %h/%h/%h/%b", $time, what,
				got.data, got.keep, got.user, got.last, exp.data, exp.keep, exp.user, exp.last);
		end
	endtask

	task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("Error at %0t ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_err(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("Error at %0t ns: %s pslverr %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic apb_xfer(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		int n;
		rdata = '0;
		err = 1'b0;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		@(posedge clk);
		#2;
		penable = 1'b1;
		for (n = 0; n < timeout_cycles; n++) begin
			@(negedge clk);
			if (pready) break;
		end
		if (n == timeout_cycles) begin
			timeouts++;
			$display("timeout: pready never rose for address %h", addr);
		end else begin
			rdata = prdata;
			err = pslverr;
		end
		@(posedge clk);
		#2;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
		logic [31:0] unused;
		apb_xfer(1'b1, addr, data, unused, err);
		if (addr < 128) begin
			prof_bits[addr[6:3]][32 * addr[2] +: 32] = data;
		end
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
		apb_xfer(1'b0, addr, '0, data, err);
	endtask

	task automatic write_profile(input int p, input deparse_act_t a0, input deparse_act_t a1,
		input deparse_act_t a2, input deparse_act_t a3);
		logic err;
		apb_write(8'(p * 8), {a1, a0}, err);
		check_err(err, 1'b0, "profile write low");
		apb_write(8'(p * 8 + 4), {a3, a2}, err);
		check_err(err, 1'b0, "profile write high");
	endtask

	// random packet and phv, expected output from the action rules
	task automatic build_packet(input int nbeats, input logic [3:0] prof);
		logic [7:0] pkt_bytes [];
		logic [7:0] out_bytes [];
		logic [15:0] c2 [n_cont];
		logic [31:0] c4 [n_cont];
		logic [47:0] c6 [n_cont];
		logic [47:0] val;
		logic [data_w-1:0] din;
		logic [data_w-1:0] dout;
		logic [keep_w-1:0] keep;
		logic [user_w-1:0] user;
		phv_t phv;
		deparse_act_t act;
		int n;
		int pos;
		pkt_bytes = new[nbeats * 8];
		for (int i = 0; i < nbeats * 8; i++) begin
			pkt_bytes[i] = 8'(rand_bits(8));
		end
		phv = '0;
		phv[15:0] = {12'(rand_bits(12)), prof};
		for (int i = 0; i < n_cont; i++) begin
			c2[i] = 16'(rand_bits(16));
			c4[i] = 32'(rand_bits(32));
			c6[i] = 48'(rand_bits(48));
			phv[16 + 16 * i +: 16] = c2[i];
			phv[80 + 32 * i +: 32] = c4[i];
			phv[208 + 48 * i +: 48] = c6[i];
		end
		out_bytes = pkt_bytes;
		for (int l = 0; l < n_lanes; l++) begin
			act = deparse_act_t'(prof_bits[prof][16 * l +: 16]);
			n = size_bytes(act.size);
			if (act.valid && n != 0 && int'(act.offset) + n <= win_bytes) begin
				case (act.size)
					size_2b: val = 48'(c2[act.idx]);
					size_4b: val = 48'(c4[act.idx]);
					default: val = c6[act.idx];
				endcase
				for (int b = 0; b < n; b++) begin
					pos = int'(act.offset) + b;
					if (pos < nbeats * 8) begin
						out_bytes[pos] = val[(n - 1 - b) * 8 +: 8]; // big-endian
					end
				end
			end
		end
		for (int bt = 0; bt < nbeats; bt++) begin
			keep = (bt == nbeats - 1) ? (8'(rand_bits(8)) | 8'h01) : '1;
			user = 16'(rand_bits(16));
			for (int k = 0; k < 8; k++) begin
				din[k * 8 +: 8] = pkt_bytes[bt * 8 + k];
				dout[k * 8 +: 8] = out_bytes[bt * 8 + k];
			end
			in_q.push_back('{data: din, keep: keep, user: user, last: bt == nbeats - 1});
			exp_q.push_back('{data: dout, keep: keep, user: user, last: bt == nbeats - 1});
		end
		phv_q.push_back(phv);
	endtask

	task automatic push_beat(input pkt_beat_t b);
		int n;
		{s_pkt_data, s_pkt_keep, s_pkt_user, s_pkt_last} = b;
		s_pkt_valid = 1'b1;
		for (n = 0; n < timeout_cycles; n++) begin
			@(negedge clk);
			if (s_pkt_ready) break;
		end
		if (n == timeout_cycles) begin
			timeouts++;
			$display("timeout: packet input stayed not ready at %0t ns", $time);
		end
		@(posedge clk);
		#2;
		s_pkt_valid = 1'b0;
	endtask

	task automatic push_phv(input phv_t p);
		int n;
		s_phv = p;
		s_phv_valid = 1'b1;
		for (n = 0; n < timeout_cycles; n++) begin
			@(negedge clk);
			if (s_phv_ready) break;
		end
		if (n == timeout_cycles) begin
			timeouts++;
			$display("timeout: PHV input stayed not ready at %0t ns", $time);
		end
		@(posedge clk);
		#2;
		s_phv_valid = 1'b0; // one PHV per packet
	endtask

	task automatic send_packet();
		pkt_beat_t b;
		fork
			push_phv(phv_q.pop_front());
			begin
				do begin
					b = in_q.pop_front();
					push_beat(b);
				end while (!b.last);
			end
		join
	endtask

	task automatic expect_packet();
		pkt_beat_t exp;
		pkt_beat_t got;
		int n;
		do begin
			exp = exp_q.pop_front();
			for (n = 0; n < timeout_cycles; n++) begin
				@(negedge clk);
				if (m_valid && m_ready) break;
			end
			if (n == timeout_cycles) begin
				timeouts++;
				$display("timeout: no output beat at %0t ns", $time);
			end else begin
				got = '{data: m_data, keep: m_keep, user: m_user, last: m_last};
				check_beat(got, exp, "output beat");
			end
		end while (!exp.last && exp_q.size() != 0);
	endtask

	task automatic run_packets();
		fork
			while (phv_q.size() != 0) send_packet();
			while (exp_q.size() != 0) expect_packet();
		join
		@(posedge clk);
		#2;
	endtask

	task automatic apb_profiles();
		logic [31:0] rd;
		logic err;
		write_profile(1, mk_act(1, size_2b, 0, 0), mk_act(1, size_4b, 1, 4), '0, '0);
		write_profile(2, mk_act(1, size_2b, 1, 0), mk_act(1, size_4b, 2, 2),
			mk_act(1, size_6b, 3, 6), mk_act(0, size_2b, 0, 0));
		write_profile(3, mk_act(1, size_6b, 0, 4), mk_act(1, size_2b, 2, 10),
			mk_act(1, size_4b, 3, 12), mk_act(1, size_4b, 1, 0));
		write_profile(4, mk_act(0, size_2b, 0, 0), mk_act(1, size_4b, 2, 13),
			mk_act(1, size_4b, 0, 4), mk_act(1, size_4b, 1, 6));
		write_profile(5, mk_act(1, size_6b, 2, 10), mk_act(1, size_2b, 3, 14),
			mk_act(1, size_4b, 0, 8), '0);
		apb_write(8'd136, 32'hdead_beef, err); // aliases profile 1
		check_err(err, 1'b1, "write above 127");
		apb_read(8'd200, rd, err);
		check_err(err, 1'b1, "read above 127");
		for (int p = 0; p < 6; p++) begin
			for (int h = 0; h < 2; h++) begin
				apb_read(8'(p * 8 + h * 4), rd, err);
				check_err(err, 1'b0, "profile read");
				check_word(rd, prof_bits[p][32 * h +: 32], "profile read back");
			end
		end
	endtask

	task automatic one_beat_rewrite();
		build_packet(1, 4'd2);
		run_packets();
	endtask

	task automatic long_packet_rewrite();
		build_packet(6, 4'd3);
		run_packets();
	endtask

	task automatic skip_and_overlap();
		build_packet(2, 4'd4);
		build_packet(3, 4'd0); // reset profile, no change
		run_packets();
	endtask

	task automatic back_to_back_stall();
		@(negedge clk);
		bp_en = 1'b1;
		@(posedge clk);
		#2;
		build_packet(3, 4'd2);
		build_packet(1, 4'd5);
		build_packet(6, 4'd3);
		build_packet(2, 4'd4);
		build_packet(4, 4'd0);
		build_packet(5, 4'd1);
		build_packet(2, 4'd5);
		run_packets();
		@(negedge clk);
		bp_en = 1'b0;
		@(posedge clk);
		#2;
	endtask

	initial begin
		aresetn = 1'b0;
		{s_pkt_data, s_pkt_keep, s_pkt_user, s_pkt_last, s_pkt_valid} = '0;
		s_phv = '0;
		s_phv_valid = 1'b0;
		m_ready = 1'b0;
		{psel, penable, pwrite, paddr, pwdata} = '0;
		for (int i = 0; i < prof_depth; i++) begin
			prof_bits[i] = '0;
		end
		repeat (4) @(posedge clk);
		#2;
		aresetn = 1'b1;
		@(posedge clk);
		#2;
		apb_profiles();
		one_beat_rewrite();
		long_packet_rewrite();
		skip_and_overlap();
		back_to_back_stall();
		$display("deparser_tb: %0d errors, %0d timeouts, %0d assertion failures", errors,
			timeouts, i_deparser_top.i_checker.fail_count);
		if (errors == 0 && timeouts == 0 && i_deparser_top.i_checker.fail_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/deparser_checker.sv ====
`default_nettype none

module deparser_checker (
	input logic                                clk,
	input logic                                aresetn,
	input logic [deparser_pkg::data_w-1:0]     m_data,
	input logic [deparser_pkg::keep_w-1:0]     m_keep,
	input logic [deparser_pkg::user_w-1:0]     m_user,
	input logic                                m_last,
	input logic                                m_valid,
	input logic                                m_ready,
	input logic                                psel,
	input logic                                penable,
	input logic [deparser_pkg::apb_addr_w-1:0] paddr,
	input logic                                pslverr
);

	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;

	// stalled output must hold
	a_out_hold: assert property (@(posedge clk) disable iff (!aresetn)
		m_valid && !m_ready |=> m_valid && $stable(m_data) && $stable(m_keep)
			&& $stable(m_user) && $stable(m_last))
	else begin
		fail_count++;
		$error("output changed while m_valid was high and m_ready low");
	end

	a_rst_valid: assert property (@(posedge clk) !aresetn |-> !m_valid)
	else begin
		fail_count++;
		$error("m_valid high during reset");
	end

	// error only in an access phase to 128 and up
	a_err_phase: assert property (@(posedge clk)
		pslverr == (psel && penable && paddr >= 8'd128))
	else begin
		fail_count++;
		$error("pslverr does not match the APB access phase and address");
	end

endmodule

bind deparser_top deparser_checker i_checker (
	.clk    (clk),
	.aresetn(aresetn),
	.m_data (m_data),
	.m_keep (m_keep),
	.m_user (m_user),
	.m_last (m_last),
	.m_valid(m_valid),
	.m_ready(m_ready),
	.psel   (psel),
	.penable(penable),
	.paddr  (paddr),
	.pslverr(pslverr)
);

`default_nettype wire

// ==== hw/deparser_top.sv ====
`default_nettype none

module deparser_top (
	input  logic                                clk,
	input  logic                                aresetn,
	input  logic [deparser_pkg::data_w-1:0]     s_pkt_data,
	input  logic [deparser_pkg::keep_w-1:0]     s_pkt_keep,
	input  logic [deparser_pkg::user_w-1:0]     s_pkt_user,
	input  logic                                s_pkt_last,
	input  logic                                s_pkt_valid,
	output logic                                s_pkt_ready,
	input  deparser_pkg::phv_t                  s_phv,
	input  logic                                s_phv_valid,
	output logic                                s_phv_ready,
	output logic [deparser_pkg::data_w-1:0]     m_data,
	output logic [deparser_pkg::keep_w-1:0]     m_keep,
	output logic [deparser_pkg::user_w-1:0]     m_user,
	output logic                                m_last,
	output logic                                m_valid,
	input  logic                                m_ready,
	input  logic                                psel,
	input  logic                                penable,
	input  logic                                pwrite,
	input  logic [deparser_pkg::apb_addr_w-1:0] paddr,
	input  logic [31:0]                         pwdata,
	output logic [31:0]                         prdata,
	output logic                                pready,
	output logic                                pslverr
);

	import deparser_pkg::*;

	pkt_beat_t pkt_in;
	pkt_beat_t pkt_head;
	phv_t phv_head;
	logic pkt_empty;
	logic pkt_full;
	logic pkt_rd_en;
	logic phv_empty;
	logic phv_full;
	logic phv_rd_en;
	logic [prof_aw-1:0] prof_addr;
	profile_t prof_data;

	assign pkt_in = '{data: s_pkt_data, keep: s_pkt_keep, user: s_pkt_user, last: s_pkt_last};
	assign s_pkt_ready = !pkt_full;
	assign s_phv_ready = !phv_full;

	sync_fifo #(
		.payload_t(pkt_beat_t),
		.depth    (fifo_depth)
	) i_pkt_fifo (
		.clk    (clk),
		.aresetn(aresetn),
		.wr_en  (s_pkt_valid),
		.wr_data(pkt_in),
		.rd_en  (pkt_rd_en),
		.rd_data(pkt_head),
		.empty  (pkt_empty),
		.full   (pkt_full)
	);

	sync_fifo #(
		.payload_t(phv_t),
		.depth    (fifo_depth)
	) i_phv_fifo (
		.clk    (clk),
		.aresetn(aresetn),
		.wr_en  (s_phv_valid),
		.wr_data(s_phv),
		.rd_en  (phv_rd_en),
		.rd_data(phv_head),
		.empty  (phv_empty),
		.full   (phv_full)
	);

	deparser i_deparser (
		.clk      (clk),
		.aresetn  (aresetn),
		.pkt_head (pkt_head),
		.pkt_empty(pkt_empty),
		.pkt_rd_en(pkt_rd_en),
		.phv_head (phv_head),
		.phv_empty(phv_empty),
		.phv_rd_en(phv_rd_en),
		.prof_addr(prof_addr),
		.prof_data(prof_data),
		.m_data   (m_data),
		.m_keep   (m_keep),
		.m_user   (m_user),
		.m_last   (m_last),
		.m_valid  (m_valid),
		.m_ready  (m_ready)
	);

	deparse_act_ram i_act_ram (
		.clk      (clk),
		.aresetn  (aresetn),
		.psel     (psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.paddr    (paddr),
		.pwdata   (pwdata),
		.prdata   (prdata),
		.pready   (pready),
		.pslverr  (pslverr),
		.prof_addr(prof_addr),
		.prof_data(prof_data)
	);

endmodule

`default_nettype wire

// ==== hw/deparser.sv ====
`default_nettype none

module deparser (
	input  logic                             clk,
	input  logic                             aresetn,
	input  deparser_pkg::pkt_beat_t          pkt_head,
	input  logic                             pkt_empty,
	output logic                             pkt_rd_en,
	input  deparser_pkg::phv_t               phv_head,
	input  logic                             phv_empty,
	output logic                             phv_rd_en,
	output logic [deparser_pkg::prof_aw-1:0] prof_addr,
	input  deparser_pkg::profile_t           prof_data,
	output logic [deparser_pkg::data_w-1:0]  m_data,
	output logic [deparser_pkg::keep_w-1:0]  m_keep,
	output logic [deparser_pkg::user_w-1:0]  m_user,
	output logic                             m_last,
	output logic                             m_valid,
	input  logic                             m_ready
);

	import deparser_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_cap1,
		st_issue,
		st_apply,
		st_flush0,
		st_flush1,
		st_stream
	} state_t;

	state_t state;
	state_t state_next;

	logic [win_bytes*8-1:0] win_data;
	logic [win_bytes*8-1:0] win_patched;
	logic [keep_w-1:0] win_keep [win_beats];
	logic [user_w-1:0] win_user [win_beats];
	logic [win_beats-1:0] win_last;
	logic cap_beat;
	logic flush_beat;

	logic act_valid;
	logic [3:0] act_off [n_lanes];
	logic [n_lanes-1:0] lane_valid;
	logic [47:0] lane_val [n_lanes];
	cont_size_t lane_size [n_lanes];

	assign prof_addr = phv_head[prof_aw-1:0]; // profile in low metadata bits
	assign cap_beat = (state == st_cap1);
	assign flush_beat = (state == st_flush1);

	for (genvar l = 0; l < n_lanes; l++) begin : g_lane
		sub_deparser i_sub_deparser (
			.clk      (clk),
			.aresetn  (aresetn),
			.act_valid(act_valid),
			.act      (prof_data[l]),
			.phv      (phv_head),
			.val_valid(lane_valid[l]),
			.val      (lane_val[l]),
			.val_size (lane_size[l])
		);
	end

	// lane order, so higher lanes win on overlap
	always_comb begin
		int nbytes;
		int base;
		win_patched = win_data;
		for (int l = 0; l < n_lanes; l++) begin
			nbytes = 2 * int'(lane_size[l]);
			base = int'(act_off[l]);
			if (nbytes != 0 && base + nbytes <= win_bytes) begin
				for (int b = 0; b < 6; b++) begin
					if (b < nbytes) begin
						win_patched[(base + b) * 8 +: 8] = lane_val[l][(nbytes - 1 - b) * 8 +: 8];
					end
				end
			end
		end
	end

	always_comb begin
		state_next = state;
		pkt_rd_en = 1'b0;
		phv_rd_en = 1'b0;
		act_valid = 1'b0;
		m_valid = 1'b0;
		m_data = pkt_head.data;
		m_keep = pkt_head.keep;
		m_user = pkt_head.user;
		m_last = pkt_head.last;
		unique case (state)
			st_idle: begin
				if (!pkt_empty && !phv_empty) begin
					pkt_rd_en = 1'b1;
					state_next = pkt_head.last ? st_issue : st_cap1;
				end
			end
			st_cap1: begin
				if (!pkt_empty) begin
					pkt_rd_en = 1'b1;
					state_next = st_issue;
				end
			end
			st_issue: begin
				act_valid = 1'b1;
				state_next = st_apply;
			end
			st_apply: begin
				if (&lane_valid) begin
					state_next = st_flush0;
				end
			end
			st_flush0, st_flush1: begin
				m_valid = 1'b1;
				m_data = win_data[flush_beat * data_w +: data_w];
				m_keep = win_keep[flush_beat];
				m_user = win_user[flush_beat];
				m_last = win_last[flush_beat];
				if (m_ready) begin
					phv_rd_en = (state == st_flush0);
					if (win_last[flush_beat]) begin
						state_next = st_idle;
					end else begin
						state_next = flush_beat ? st_stream : st_flush1;
					end
				end
			end
			st_stream: begin
				m_valid = !pkt_empty;
				pkt_rd_en = !pkt_empty && m_ready;
				if (pkt_rd_en && pkt_head.last) begin
					state_next = st_idle;
				end
			end
			default: state_next = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			state <= st_idle;
		end else begin
			state <= state_next;
		end
	end

	always_ff @(posedge clk) begin
		if (pkt_rd_en && state != st_stream) begin // header beat capture
			win_data[cap_beat * data_w +: data_w] <= pkt_head.data;
			win_keep[cap_beat] <= pkt_head.keep;
			win_user[cap_beat] <= pkt_head.user;
			win_last[cap_beat] <= pkt_head.last;
		end
		if (state == st_issue) begin
			for (int l = 0; l < n_lanes; l++) begin
				act_off[l] <= prof_data[l].offset;
			end
		end
		if (state == st_apply && &lane_valid) begin
			win_data <= win_patched;
		end
	end

endmodule

`default_nettype wire

// ==== hw/deparse_act_ram.sv ====
`default_nettype none

module deparse_act_ram (
	input  logic                                clk,
	input  logic                                aresetn,
	input  logic                                psel,
	input  logic                                penable,
	input  logic                                pwrite,
	input  logic [deparser_pkg::apb_addr_w-1:0] paddr,
	input  logic [31:0]                         pwdata,
	output logic [31:0]                         prdata,
	output logic                                pready,
	output logic                                pslverr,
	input  logic [deparser_pkg::prof_aw-1:0]    prof_addr,
	output deparser_pkg::profile_t              prof_data
);

	import deparser_pkg::*;

	logic [$bits(profile_t)-1:0] mem [prof_depth];
	logic access;
	logic addr_err;
	logic [prof_aw-1:0] apb_idx;
	logic apb_hi;

	assign access = psel && penable;
	assign addr_err = paddr[apb_addr_w-1]; // 128 and up
	assign apb_idx = paddr[3 +: prof_aw];
	assign apb_hi = paddr[2];

	assign pready = access; // no wait states
	assign pslverr = access && addr_err;
	assign prdata = addr_err ? '0 : mem[apb_idx][32 * apb_hi +: 32];

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			for (int i = 0; i < prof_depth; i++) begin
				mem[i] <= '0;
			end
		end else if (access && pwrite && !addr_err) begin
			mem[apb_idx][32 * apb_hi +: 32] <= pwdata;
		end
	end

	// lookup sees the entry before a same-cycle write
	always_ff @(posedge clk) begin
		prof_data <= mem[prof_addr];
	end

endmodule

`default_nettype wire

// ==== hw/sub_deparser.sv ====
`default_nettype none

module sub_deparser (
	input  logic                      clk,
	input  logic                      aresetn,
	input  logic                      act_valid,
	input  deparser_pkg::deparse_act_t act,
	input  deparser_pkg::phv_t        phv,
	output logic                      val_valid,
	output logic [47:0]               val,
	output deparser_pkg::cont_size_t  val_size
);

	import deparser_pkg::*;

	logic [47:0] sel;

	// container pick, right aligned
	always_comb begin
		sel = '0;
		unique case (act.size)
			size_2b: sel[15:0] = phv[cont2_lsb + 16 * act.idx +: 16];
			size_4b: sel[31:0] = phv[cont4_lsb + 32 * act.idx +: 32];
			size_6b: sel = phv[cont6_lsb + 48 * act.idx +: 48];
			default: sel = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			val_valid <= 1'b0;
			val_size <= size_none;
		end else begin
			val_valid <= act_valid;
			if (act_valid) begin
				val_size <= act.valid ? act.size : size_none;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (act_valid) begin
			val <= sel;
		end
	end

endmodule

`default_nettype wire

// ==== hw/sync_fifo.sv ====
`default_nettype none

module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int depth = 8
) (
	input  logic     clk,
	input  logic     aresetn,
	input  logic     wr_en,
	input  payload_t wr_data,
	input  logic     rd_en,
	output payload_t rd_data,
	output logic     empty,
	output logic     full
);

	payload_t mem [depth];
	logic [$clog2(depth)-1:0] wr_ptr;
	logic [$clog2(depth)-1:0] rd_ptr;
	logic [$clog2(depth):0] count;
	logic do_wr;
	logic do_rd;

	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;
	assign empty = (count == 0);
	assign full = (count == depth);
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= (wr_ptr == depth - 1) ? '0 : wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= (rd_ptr == depth - 1) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + do_wr - do_rd; // both at once keeps the count
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

endmodule

`default_nettype wire

// ==== hw/deparser_pkg.sv ====
`default_nettype none

package deparser_pkg;

	localparam int data_w = 64;
	localparam int keep_w = 8;
	localparam int user_w = 16;
	localparam int win_beats = 2;
	localparam int win_bytes = 16;
	localparam int n_lanes = 4;
	localparam int n_cont = 4;
	localparam int meta_w = 16;
	localparam int phv_w = 400;
	localparam int prof_depth = 16;
	localparam int prof_aw = $clog2(prof_depth);
	localparam int fifo_depth = 8;
	localparam int apb_addr_w = 8;

	// container base bits inside the phv
	localparam int cont2_lsb = meta_w;
	localparam int cont4_lsb = cont2_lsb + n_cont * 16;
	localparam int cont6_lsb = cont4_lsb + n_cont * 32;

	typedef enum logic [1:0] {
		size_none = 2'd0,
		size_2b   = 2'd1,
		size_4b   = 2'd2,
		size_6b   = 2'd3
	} cont_size_t;

	typedef struct packed {
		logic [6:0] rsvd;
		logic [3:0] offset; // byte offset into the window
		logic [1:0] idx;
		cont_size_t size;
		logic       valid;
	} deparse_act_t;

	typedef deparse_act_t [n_lanes-1:0] profile_t; // action 0 in bits 15:0

	typedef struct packed {
		logic [data_w-1:0] data;
		logic [keep_w-1:0] keep;
		logic [user_w-1:0] user;
		logic              last;
	} pkt_beat_t;

	typedef logic [phv_w-1:0] phv_t;

endpackage

`default_nettype wire
